/* flist.f */
source/qe_reg_pkg.sv
source/qe_enc_pkg.sv
source/qe_channel_regs.sv
source/qe_sim_generator.sv
source/qe_input_select.sv
source/qe_decoder.sv
source/qe_position_counters.sv
source/qe_channel.sv
tests/qe_channel_tb.sv

/* source/qe_channel.sv */
////////////////////////////////////////
// quadrature encoder channel
// registers, generator, input select,
// decoder and counters on a strobe bus
////////////////////////////////////////
module qe_channel #(
    parameter qe_reg_pkg::reg_addr_t base_addr = 8'h00
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  qe_reg_pkg::reg_addr_t addr,
    input  qe_reg_pkg::reg_word_t wr_data,
    input  logic                  ext_a,
    input  logic                  ext_b,
    input  logic                  ext_i,
    output qe_reg_pkg::reg_word_t rd_data,
    output logic                  rd_valid
);

    logic                  count_load;
    logic                  turns_load;
    qe_reg_pkg::reg_word_t load_value;
    qe_reg_pkg::reg_word_t phase_time;
    qe_reg_pkg::reg_word_t counts_per_rev;
    logic                  cfg_enable;
    qe_enc_pkg::src_e      cfg_source;
    logic                  cfg_sim_enable;
    qe_enc_pkg::dir_e      cfg_sim_dir;
    logic                  cfg_flip_ab;
    logic                  int_a;
    logic                  int_b;
    logic                  int_i;
    logic                  sel_a;
    logic                  sel_b;
    logic                  sel_i;
    logic                  step;
    logic                  index;
    qe_enc_pkg::dir_e      dir;
    qe_reg_pkg::reg_word_t position;
    qe_reg_pkg::reg_word_t turns;

    qe_channel_regs #(
        .base_addr(base_addr)
    ) u_regs (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .addr          (addr),
        .wr_data       (wr_data),
        .position      (position),
        .turns         (turns),
        .sel_a         (sel_a),
        .sel_b         (sel_b),
        .sel_i         (sel_i),
        .dir           (dir),
        .count_load    (count_load),
        .turns_load    (turns_load),
        .load_value    (load_value),
        .phase_time    (phase_time),
        .counts_per_rev(counts_per_rev),
        .cfg_enable    (cfg_enable),
        .cfg_source    (cfg_source),
        .cfg_sim_enable(cfg_sim_enable),
        .cfg_sim_dir   (cfg_sim_dir),
        .cfg_flip_ab   (cfg_flip_ab),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid)
    );

    qe_sim_generator u_generator (
        .clk           (clk),
        .reset         (reset),
        .sim_enable    (cfg_sim_enable),
        .sim_dir       (cfg_sim_dir),
        .phase_time    (phase_time),
        .counts_per_rev(counts_per_rev),
        .int_a         (int_a),
        .int_b         (int_b),
        .int_i         (int_i)
    );

    qe_input_select u_input_select (
        .clk    (clk),
        .reset  (reset),
        .ext_a  (ext_a),
        .ext_b  (ext_b),
        .ext_i  (ext_i),
        .int_a  (int_a),
        .int_b  (int_b),
        .int_i  (int_i),
        .source (cfg_source),
        .flip_ab(cfg_flip_ab),
        .sel_a  (sel_a),
        .sel_b  (sel_b),
        .sel_i  (sel_i)
    );

    qe_decoder u_decoder (
        .clk   (clk),
        .reset (reset),
        .quad_a(sel_a),
        .quad_b(sel_b),
        .quad_i(sel_i),
        .step  (step),
        .index (index),
        .dir   (dir)
    );

    qe_position_counters u_counters (
        .clk       (clk),
        .reset     (reset),
        .enable    (cfg_enable),
        .step      (step),
        .index     (index),
        .dir       (dir),
        .count_load(count_load),
        .turns_load(turns_load),
        .load_value(load_value),
        .position  (position),
        .turns     (turns)
    );

endmodule

/* source/qe_channel_regs.sv */
////////////////////////////////////////
// encoder channel register block
// decodes the strobe bus, holds the
// setup registers, issues counter loads
// and returns registered read data
////////////////////////////////////////
module qe_channel_regs #(
    parameter qe_reg_pkg::reg_addr_t base_addr = 8'h00
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  qe_reg_pkg::reg_addr_t addr,
    input  qe_reg_pkg::reg_word_t wr_data,
    input  qe_reg_pkg::reg_word_t position,
    input  qe_reg_pkg::reg_word_t turns,
    input  logic                  sel_a,
    input  logic                  sel_b,
    input  logic                  sel_i,
    input  qe_enc_pkg::dir_e      dir,
    output logic                  count_load,
    output logic                  turns_load,
    output qe_reg_pkg::reg_word_t load_value,
    output qe_reg_pkg::reg_word_t phase_time,
    output qe_reg_pkg::reg_word_t counts_per_rev,
    output logic                  cfg_enable,
    output qe_enc_pkg::src_e      cfg_source,
    output logic                  cfg_sim_enable,
    output qe_enc_pkg::dir_e      cfg_sim_dir,
    output logic                  cfg_flip_ab,
    output qe_reg_pkg::reg_word_t rd_data,
    output logic                  rd_valid
);

    qe_reg_pkg::reg_addr_t offset;
    logic                  hit;
    qe_reg_pkg::reg_word_t config_q;
    qe_reg_pkg::status_t   status;
    logic                  wr_q;
    qe_reg_pkg::reg_addr_t wr_offset_q;
    qe_reg_pkg::reg_word_t wr_data_q;

    assign offset = addr - base_addr;
    assign hit    = (addr >= base_addr) && (offset < qe_reg_pkg::num_regs);

    ////////////////////////////////////////
    // write path

    // write request held for one cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_q        <= 1'b0;
            wr_offset_q <= '0;
            wr_data_q   <= '0;
        end else begin
            wr_q        <= wr_en && hit;
            wr_offset_q <= offset;
            wr_data_q   <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase_time     <= '0;
            counts_per_rev <= '0;
            config_q       <= '0;
        end else if (wr_q) begin
            case (wr_offset_q)
                qe_reg_pkg::reg_phase_time:     phase_time     <= wr_data_q;
                qe_reg_pkg::reg_counts_per_rev: counts_per_rev <= wr_data_q;
                qe_reg_pkg::reg_config:         config_q       <= wr_data_q;
                default: ;
            endcase
        end
    end

    // count and turns live in the counter block
    assign count_load = wr_q && (wr_offset_q == qe_reg_pkg::reg_count);
    assign turns_load = wr_q && (wr_offset_q == qe_reg_pkg::reg_turns);
    assign load_value = wr_data_q;

    assign cfg_enable     = config_q[qe_reg_pkg::cfg_enable];
    assign cfg_source     = qe_enc_pkg::src_e'(config_q[qe_reg_pkg::cfg_source]);
    assign cfg_sim_enable = config_q[qe_reg_pkg::cfg_sim_enable];
    assign cfg_sim_dir    = qe_enc_pkg::dir_e'(config_q[qe_reg_pkg::cfg_sim_dir]);
    assign cfg_flip_ab    = config_q[qe_reg_pkg::cfg_flip_ab];

    ////////////////////////////////////////
    // read path

    assign status = '{dir: dir, i: sel_i, b: sel_b, a: sel_a};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= rd_en && hit;
            if (rd_en && hit) begin
                case (offset)
                    qe_reg_pkg::reg_count:          rd_data <= position;
                    qe_reg_pkg::reg_turns:          rd_data <= turns;
                    qe_reg_pkg::reg_phase_time:     rd_data <= phase_time;
                    qe_reg_pkg::reg_counts_per_rev: rd_data <= counts_per_rev;
                    qe_reg_pkg::reg_config:         rd_data <= config_q;
                    default:                        rd_data <= {28'd0, status};
                endcase
            end
        end
    end

endmodule

/* source/qe_decoder.sv */
////////////////////////////////////////
// quadrature decoder
// A/B transitions become step pulses with
// a direction, rising I an index pulse
////////////////////////////////////////
module qe_decoder (
    input  logic             clk,
    input  logic             reset,
    input  logic             quad_a,
    input  logic             quad_b,
    input  logic             quad_i,
    output logic             step,
    output logic             index,
    output qe_enc_pkg::dir_e dir
);

    logic [1:0] prev_pos;
    logic [1:0] cur_pos;
    logic [1:0] delta;
    logic       prev_i;

    // place of A/B in the clockwise cycle 00, 10, 11, 01
    assign cur_pos = {quad_b, quad_a ^ quad_b};
    assign delta   = cur_pos - prev_pos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prev_pos <= 2'd0;
            prev_i   <= 1'b0;
            step     <= 1'b0;
            index    <= 1'b0;
            dir      <= qe_enc_pkg::dir_ccw;
        end else begin
            prev_pos <= cur_pos;
            prev_i   <= quad_i;
            index    <= quad_i && !prev_i;
            // one place either way counts
            // two places means a state was missed
            step     <= (delta == 2'd1) || (delta == 2'd3);
            if (delta == 2'd1) begin
                dir <= qe_enc_pkg::dir_cw;
            end else if (delta == 2'd3) begin
                dir <= qe_enc_pkg::dir_ccw;
            end
        end
    end

endmodule

/* source/qe_enc_pkg.sv */
////////////////////////////////////////
// encoder channel types
// direction, input source and the
// generator FSM states
////////////////////////////////////////
package qe_enc_pkg;

    typedef enum logic {
        dir_ccw = 1'b0,
        dir_cw  = 1'b1
    } dir_e;

    typedef enum logic {
        src_internal = 1'b0,
        src_external = 1'b1
    } src_e;

    typedef enum logic [2:0] {
        gen_idle,
        gen_load,
        gen_wait,
        gen_step,
        gen_index
    } gen_state_e;

endpackage

/* source/qe_input_select.sv */
////////////////////////////////////////
// encoder input select
// synchronizes the external lines and
// picks the source, with optional A/B swap
////////////////////////////////////////
module qe_input_select (
    input  logic             clk,
    input  logic             reset,
    input  logic             ext_a,
    input  logic             ext_b,
    input  logic             ext_i,
    input  logic             int_a,
    input  logic             int_b,
    input  logic             int_i,
    input  qe_enc_pkg::src_e source,
    input  logic             flip_ab,
    output logic             sel_a,
    output logic             sel_b,
    output logic             sel_i
);

    // bit 0 is A, bit 1 is B, bit 2 is I
    logic [2:0] sync_q1;
    logic [2:0] sync_q2;
    logic       src_a;
    logic       src_b;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sync_q1 <= 3'b000;
            sync_q2 <= 3'b000;
        end else begin
            sync_q1 <= {ext_i, ext_b, ext_a};
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        if (source == qe_enc_pkg::src_external) begin
            src_a = sync_q2[0];
            src_b = sync_q2[1];
            sel_i = sync_q2[2];
        end else begin
            src_a = int_a;
            src_b = int_b;
            sel_i = int_i;
        end
    end

    // swapping A and B reverses the decoded direction
    assign sel_a = flip_ab ? src_b : src_a;
    assign sel_b = flip_ab ? src_a : src_b;

endmodule

/* source/qe_position_counters.sv */
////////////////////////////////////////
// position and turns counters
// count steps and index pulses in the
// decoded direction, loadable from the bus
////////////////////////////////////////
module qe_position_counters (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic                  step,
    input  logic                  index,
    input  qe_enc_pkg::dir_e      dir,
    input  logic                  count_load,
    input  logic                  turns_load,
    input  qe_reg_pkg::reg_word_t load_value,
    output qe_reg_pkg::reg_word_t position,
    output qe_reg_pkg::reg_word_t turns
);

    // one count up for clockwise, down otherwise
    function automatic qe_reg_pkg::reg_word_t move(
        input qe_reg_pkg::reg_word_t value,
        input qe_enc_pkg::dir_e      d
    );
        if (d == qe_enc_pkg::dir_cw) begin
            return value + 1'b1;
        end
        return value - 1'b1;
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            position <= '0;
        end else if (count_load) begin
            position <= load_value;
        end else if (enable && step) begin
            position <= move(position, dir);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            turns <= '0;
        end else if (turns_load) begin
            turns <= load_value;
        end else if (enable && index) begin
            turns <= move(turns, dir);
        end
    end

endmodule

/* source/qe_reg_pkg.sv */
////////////////////////////////////////
// encoder channel register map
// bus word and address types, register
// offsets, config bits and status layout
////////////////////////////////////////
package qe_reg_pkg;

    typedef logic [31:0] reg_word_t;
    typedef logic [7:0]  reg_addr_t;

    // offsets from the channel base address
    typedef enum logic [7:0] {
        reg_count          = 8'd0,
        reg_turns          = 8'd1,
        reg_phase_time     = 8'd2,
        reg_counts_per_rev = 8'd3,
        reg_config         = 8'd4,
        reg_status         = 8'd5
    } reg_offset_e;

    localparam int num_regs = 6;

    // bit positions in the config register
    localparam int cfg_enable     = 0;
    localparam int cfg_source     = 1;
    localparam int cfg_sim_enable = 2;
    localparam int cfg_sim_dir    = 3;
    localparam int cfg_flip_ab    = 4;

    // live encoder levels, zero-extended on read
    typedef struct packed {
        logic dir;
        logic i;
        logic b;
        logic a;
    } status_t;

endpackage

/* source/qe_sim_generator.sv */
////////////////////////////////////////
// quadrature signal generator
// steps a Gray phase every phase_time
// cycles and raises I once per revolution
////////////////////////////////////////
module qe_sim_generator (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sim_enable,
    input  qe_enc_pkg::dir_e      sim_dir,
    input  qe_reg_pkg::reg_word_t phase_time,
    input  qe_reg_pkg::reg_word_t counts_per_rev,
    output logic                  int_a,
    output logic                  int_b,
    output logic                  int_i
);

    qe_enc_pkg::gen_state_e state;
    qe_reg_pkg::reg_word_t  timer;
    qe_reg_pkg::reg_word_t  pulse_count;
    logic [1:0]             phase;
    logic                   rev_done;

    // this step completes a revolution
    assign rev_done = (pulse_count + 1'b1) == counts_per_rev;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= qe_enc_pkg::gen_idle;
            timer       <= '0;
            pulse_count <= '0;
            phase       <= 2'd0;
            int_i       <= 1'b0;
        end else begin
            case (state)
                qe_enc_pkg::gen_idle: begin
                    if (sim_enable) begin
                        state <= qe_enc_pkg::gen_load;
                    end
                end
                qe_enc_pkg::gen_load: begin
                    timer <= phase_time;
                    if (sim_enable) begin
                        state <= qe_enc_pkg::gen_wait;
                    end else begin
                        state <= qe_enc_pkg::gen_idle;
                    end
                end
                qe_enc_pkg::gen_wait: begin
                    if (!sim_enable) begin
                        state <= qe_enc_pkg::gen_idle;
                    end else if (timer == '0) begin
                        state <= qe_enc_pkg::gen_step;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                qe_enc_pkg::gen_step: begin
                    // index drops with the next edge on A or B
                    int_i <= 1'b0;
                    if (sim_dir == qe_enc_pkg::dir_cw) begin
                        phase <= phase + 2'd1;
                    end else begin
                        phase <= phase - 2'd1;
                    end
                    if (rev_done) begin
                        pulse_count <= '0;
                        state       <= qe_enc_pkg::gen_index;
                    end else begin
                        pulse_count <= pulse_count + 1'b1;
                        state       <= qe_enc_pkg::gen_load;
                    end
                end
                qe_enc_pkg::gen_index: begin
                    int_i <= 1'b1;
                    state <= qe_enc_pkg::gen_load;
                end
                default: begin
                    state <= qe_enc_pkg::gen_idle;
                end
            endcase
        end
    end

    // phase 0..3 maps to A/B as 00, 10, 11, 01
    assign int_a = phase[1] ^ phase[0];
    assign int_b = phase[1];

endmodule

/* tests/qe_channel_tb.sv */
////////////////////////////////////////
// encoder channel testbench
// table driven bus accesses, external
// encoder steps and generator runs
////////////////////////////////////////
module qe_channel_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam qe_reg_pkg::reg_addr_t base_addr = 8'h20;
    localparam int max_entries = 48;

    typedef enum logic [1:0] {op_write, op_read, op_ext_step, op_run_sim} op_e;

    logic                  clk;
    logic                  reset;
    logic                  wr_en;
    logic                  rd_en;
    qe_reg_pkg::reg_addr_t addr;
    qe_reg_pkg::reg_word_t wr_data;
    logic                  ext_a;
    logic                  ext_b;
    logic                  ext_i;
    qe_reg_pkg::reg_word_t rd_data;
    logic                  rd_valid;

    // stimulus table
    op_e                   ops   [max_entries];
    qe_reg_pkg::reg_addr_t addrs [max_entries];
    qe_reg_pkg::reg_word_t datas [max_entries];
    qe_reg_pkg::reg_word_t exps  [max_entries];
    string                 names [max_entries];
    int                    num_entries = 0;
    logic                  table_ready = 1'b0;

    int                    value_errors = 0;
    int                    handshake_errors = 0;
    logic [1:0]            ext_pos;
    logic [1:0]            model_pos;
    qe_reg_pkg::reg_word_t rnd [8];
    qe_reg_pkg::reg_word_t rd_word;
    logic                  rd_ok;

    qe_channel #(
        .base_addr(base_addr)
    ) UUT (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wr_data (wr_data),
        .ext_a   (ext_a),
        .ext_b   (ext_b),
        .ext_i   (ext_i),
        .rd_data (rd_data),
        .rd_valid(rd_valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic qe_reg_pkg::reg_addr_t reg_at(input qe_reg_pkg::reg_offset_e off);
        return base_addr + off;
    endfunction

    function automatic qe_reg_pkg::reg_word_t cfg_word(input logic en, input logic ext,
                                                       input logic sim, input logic cw,
                                                       input logic flip);
        qe_reg_pkg::reg_word_t w;
        w = '0;
        w[qe_reg_pkg::cfg_enable]     = en;
        w[qe_reg_pkg::cfg_source]     = ext;
        w[qe_reg_pkg::cfg_sim_enable] = sim;
        w[qe_reg_pkg::cfg_sim_dir]    = cw;
        w[qe_reg_pkg::cfg_flip_ab]    = flip;
        return w;
    endfunction

    // clockwise order of A/B is 00, 10, 11, 01
    // result packs b above a
    function automatic logic [1:0] ab_of(input logic [1:0] pos);
        case (pos)
            2'd0:    return 2'b00;
            2'd1:    return 2'b01;
            2'd2:    return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    function automatic qe_reg_pkg::reg_word_t status_word(input logic [1:0] pos,
                                                          input logic flip, input logic cw);
        logic [1:0]          ab;
        qe_reg_pkg::status_t s;
        ab    = ab_of(pos);
        s.dir = cw;
        s.i   = 1'b0;
        s.a   = flip ? ab[1] : ab[0];
        s.b   = flip ? ab[0] : ab[1];
        return {28'd0, s};
    endfunction

    task automatic add_entry(input op_e op, input qe_reg_pkg::reg_addr_t a,
                             input qe_reg_pkg::reg_word_t d, input qe_reg_pkg::reg_word_t e,
                             input string name);
        ops[num_entries]   = op;
        addrs[num_entries] = a;
        datas[num_entries] = d;
        exps[num_entries]  = e;
        names[num_entries] = name;
        num_entries++;
    endtask

    // step count in bits 15:0, clockwise in bit 16, index pulse in bit 17
    task automatic add_ext(input logic [15:0] n, input logic cw, input logic idx,
                           input string name);
        model_pos = cw ? model_pos + n[1:0] : model_pos - n[1:0];
        add_entry(op_ext_step, '0, {14'd0, idx, cw, n}, '0, name);
    endtask

    task automatic build_table();
        model_pos = 2'd0;
        for (int k = 0; k < 8; k++) begin
            rnd[k] = $urandom();
        end
        // register access
        add_entry(op_write, reg_at(qe_reg_pkg::reg_phase_time), rnd[0], '0, "wr phase_time");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_counts_per_rev), rnd[1], '0, "wr cpr");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), rnd[2], '0, "wr config");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_phase_time), '0, rnd[0], "rd phase_time");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_counts_per_rev), '0, rnd[1], "rd cpr");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_config), '0, rnd[2], "rd config");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), '0, '0, "clear config");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_count), rnd[3], '0, "wr count");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_count), '0, rnd[3], "rd count");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_turns), rnd[4], '0, "wr turns");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_turns), '0, rnd[4], "rd turns");
        add_entry(op_read, base_addr + 8'd6, '0, '0, "rd above range");
        add_entry(op_read, base_addr - 8'd1, '0, '0, "rd below range");
        // external counting with the source switched before enable
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), cfg_word(0, 1, 0, 0, 0), '0, "ext");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_count), rnd[5], '0, "load cw");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), cfg_word(1, 1, 0, 0, 0), '0, "en");
        add_ext(16'd10, 1'b1, 1'b0, "ext cw");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_count), '0, rnd[5] + 32'd10, "count cw");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_count), rnd[6], '0, "load ccw");
        add_ext(16'd7, 1'b0, 1'b0, "ext ccw");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_count), '0, rnd[6] - 32'd7, "count ccw");
        // flipped A/B and then counting disabled
        add_entry(op_write, reg_at(qe_reg_pkg::reg_count), rnd[7], '0, "load flip");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), cfg_word(1, 1, 0, 0, 1), '0, "flip");
        add_ext(16'd6, 1'b1, 1'b0, "ext flip");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_count), '0, rnd[7] - 32'd6, "count flip");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_status), '0, status_word(model_pos, 1, 0),
                  "status flip");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), cfg_word(0, 1, 0, 0, 0), '0, "dis");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_count), rnd[3], '0, "load dis");
        add_ext(16'd5, 1'b1, 1'b0, "ext dis");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_count), '0, rnd[3], "count dis");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_status), '0, status_word(model_pos, 0, 1),
                  "status dis");
        // external index
        add_entry(op_write, reg_at(qe_reg_pkg::reg_config), cfg_word(1, 1, 0, 0, 0), '0, "en");
        add_entry(op_write, reg_at(qe_reg_pkg::reg_turns), rnd[4], '0, "load turns");
        add_ext(16'd3, 1'b1, 1'b1, "index cw");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_turns), '0, rnd[4] + 32'd1, "turns cw");
        add_ext(16'd3, 1'b0, 1'b1, "index ccw");
        add_entry(op_read, reg_at(qe_reg_pkg::reg_turns), '0, rnd[4], "turns ccw");
        // internal generator
        add_entry(op_run_sim, '0, 32'd1, '0, "sim cw");
        add_entry(op_run_sim, '0, 32'd0, '0, "sim ccw");
    endtask

    ////////////////////////////////////////
    // bus and encoder drivers

    task automatic reset_dut();
        @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic bus_write(input qe_reg_pkg::reg_addr_t a, input qe_reg_pkg::reg_word_t d);
        @(posedge clk);
        wr_en   <= 1'b1;
        addr    <= a;
        wr_data <= d;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    task automatic bus_read(input qe_reg_pkg::reg_addr_t a, output qe_reg_pkg::reg_word_t d,
                            output logic valid);
        @(posedge clk);
        rd_en <= 1'b1;
        addr  <= a;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        valid = rd_valid;
        d     = rd_data;
        @(negedge clk);
        if (rd_valid) begin
            handshake_errors++;
            $display("rd_valid stayed high longer than one cycle at address %h", a);
        end
    endtask

    task automatic apply_ext_steps(input qe_reg_pkg::reg_word_t d);
        logic [1:0] ab;
        for (int k = 0; k < d[15:0]; k++) begin
            ext_pos = d[16] ? ext_pos + 2'd1 : ext_pos - 2'd1;
            ab      = ab_of(ext_pos);
            @(posedge clk);
            ext_a <= ab[0];
            ext_b <= ab[1];
            repeat (7) @(posedge clk);
        end
        if (d[17]) begin
            @(posedge clk);
            ext_i <= 1'b1;
            repeat (8) @(posedge clk);
            ext_i <= 1'b0;
            repeat (8) @(posedge clk);
        end
    endtask

    task automatic check_word(input string name, input qe_reg_pkg::reg_word_t expected,
                              input qe_reg_pkg::reg_word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input qe_reg_pkg::status_t expected,
                                input qe_reg_pkg::status_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Error: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // generator run from a fresh reset so the revolution count starts at zero
    task automatic run_generator(input logic cw, input string name);
        qe_reg_pkg::reg_word_t count_val;
        qe_reg_pkg::reg_word_t turns_val;
        logic                  ok_c;
        logic                  ok_t;
        int                    run_cycles;
        reset_dut();
        bus_write(reg_at(qe_reg_pkg::reg_phase_time), 32'd3);
        bus_write(reg_at(qe_reg_pkg::reg_counts_per_rev), 32'd8);
        bus_write(reg_at(qe_reg_pkg::reg_count), '0);
        bus_write(reg_at(qe_reg_pkg::reg_turns), '0);
        bus_write(reg_at(qe_reg_pkg::reg_config), cfg_word(1, 0, 0, cw, 0));
        bus_write(reg_at(qe_reg_pkg::reg_config), cfg_word(1, 0, 1, cw, 0));
        run_cycles = $urandom_range(400, 200);
        repeat (run_cycles) @(posedge clk);
        bus_write(reg_at(qe_reg_pkg::reg_config), cfg_word(1, 0, 0, cw, 0));
        repeat (20) @(posedge clk);
        bus_read(reg_at(qe_reg_pkg::reg_count), count_val, ok_c);
        bus_read(reg_at(qe_reg_pkg::reg_turns), turns_val, ok_t);
        if (!ok_c || !ok_t) begin
            handshake_errors++;
            $display("%s: no rd_valid when reading the counters", name);
        end else if (cw) begin
            if ($signed(count_val) <= 0) begin
                value_errors++;
                $display("Error: %s expected a positive count actual %0d", name,
                         $signed(count_val));
            end
            check_word(name, count_val / 8, turns_val);
        end else begin
            if ($signed(count_val) >= 0) begin
                value_errors++;
                $display("Error: %s expected a negative count actual %0d", name,
                         $signed(count_val));
            end
            check_word(name, -((-count_val) / 8), turns_val);
        end
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        reset   = 1'b0;
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        addr    = '0;
        wr_data = '0;
        ext_a   = 1'b0;
        ext_b   = 1'b0;
        ext_i   = 1'b0;
        ext_pos = 2'd0;
        void'($urandom(62312));
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        for (int k = 0; k < num_entries; k++) begin
            case (ops[k])
                op_write: bus_write(addrs[k], datas[k]);
                op_read: begin
                    bus_read(addrs[k], rd_word, rd_ok);
                    if ((addrs[k] < base_addr) || (addrs[k] > base_addr + 8'd5)) begin
                        if (rd_ok) begin
                            handshake_errors++;
                            $display("%s: rd_valid came back for an address outside the channel",
                                     names[k]);
                        end
                    end else if (!rd_ok) begin
                        handshake_errors++;
                        $display("%s: rd_valid did not arrive one cycle after rd_en", names[k]);
                    end else if (addrs[k] == reg_at(qe_reg_pkg::reg_status)) begin
                        check_status(names[k], qe_reg_pkg::status_t'(exps[k][3:0]),
                                     qe_reg_pkg::status_t'(rd_word[3:0]));
                    end else begin
                        check_word(names[k], exps[k], rd_word);
                    end
                end
                op_ext_step: apply_ext_steps(datas[k]);
                default: run_generator(datas[k][0], names[k]);
            endcase
        end
        $display("errors: %0d value, %0d handshake", value_errors, handshake_errors);
        if ((value_errors == 0) && (handshake_errors == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // time limit scales with the table length
    initial begin
        wait (table_ready);
        #(num_entries * 400 * 8);
        $display("watchdog expired before the stimulus table was finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
